//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = ifu_fetch_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) source/fetch_defs.svh
PASS_MSG  = ALL TESTS PASSED

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) fetch_rom.hex
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/ifu_fetch_tb.sv
// Fetch front end testbench: flush rows from a table, delivered words checked against a ROM copy
`timescale 1ns/1ps
`include "fetch_defs.svh"

module ifu_fetch_tb
   import fetch_ctl_pkg::*;
   import fetch_buf_pkg::*;
();

   localparam int          NUM_ROWS = 10;
   localparam int          TIMEOUT  = 200;           // Cycles per wait
   localparam int          HALT_CYC = 20;
   localparam int          HOLD_CYC = 10;
   localparam logic [31:0] MRAC_VAL = 32'h5555_5545;  // Region 2 uncacheable
   localparam logic [1:0]  M_ONE    = 2'd0;
   localparam logic [1:0]  M_TWO    = 2'd1;
   localparam logic [1:0]  M_BP     = 2'd2;           // Hold off, then drain by two
   localparam logic [1:0]  M_RND    = 2'd3;

   typedef struct packed {
      logic [31:0] addr;       // Flush target, byte address
      logic        noredir;
      logic [7:0]  stall_len;  // Stall burst right after the flush
      logic        stall_wr;   // Burst on ic_write_stall, else dma_stall
      logic [1:0]  mode;
      logic [7:0]  nwords;
      logic        iccm;
      logic        fault;
      logic        unc;
   } row_t;

   logic        clk, arst_n;
   logic        flush, flush_noredir, dma_stall, ic_write_stall;
   fetch_addr_t flush_path;
   logic [31:0] mrac;
   consume_op_t decode_req;
   logic        instr0_valid, instr1_valid;
   fetch_addr_t instr0_addr, instr1_addr, fetch_addr_bf;
   instr_word_t instr0_word, instr1_word;
   logic        fetch_req_bf, iccm_access_bf, region_fault_bf, uncacheable_bf;

   instr_word_t rom [`ROM_WORDS];
   row_t        rows [NUM_ROWS];
   logic [31:0] exp_addr;                  // Next expected byte address
   int          got_cnt;
   logic        s_v0, s_req;               // Sampled at the falling edge

   ifu_fetch_top ifu_fetch_top_inst (.*);

   always #5 clk = ~clk;

   // *******************************************************************
   // Compare tasks
   // *******************************************************************
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_addr(input string name, input fetch_addr_t got, input fetch_addr_t exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_word(input string name, input instr_word_t got, input instr_word_t exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input bit got, input bit exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   // *******************************************************************
   // Reference model
   // *******************************************************************
   // Next word; bit 1 only survives inside the same 16 byte line
   function automatic logic [31:0] next_seq(input logic [31:0] a);
      logic [31:0] n;
      n = {a[31:2] + 30'd1, 2'b00};
      if (n[`ICACHE_LINE_LO] == a[`ICACHE_LINE_LO]) n[1] = a[1];
      return n;
   endfunction

   function automatic consume_op_t req_for(input logic [1:0] mode);
      logic [1:0] pick;
      pick = 2'($urandom_range(2, 0));
      if (mode == M_ONE) return CONSUME_ONE;
      if (mode != M_RND) return CONSUME_TWO;  // Fixed two and back-pressure drain
      case (pick)
         2'd0:    return CONSUME_NONE;
         2'd1:    return CONSUME_ONE;
         default: return CONSUME_TWO;
      endcase
   endfunction

   task automatic take_word(input string name, input fetch_addr_t addr, input instr_word_t word);
      check_addr({name, "_addr"}, addr, exp_addr[31:1]);
      check_word({name, "_word"}, word, rom[exp_addr[7:2]]);  // ROM index is bits 7:2
      exp_addr = next_seq(exp_addr);
      got_cnt++;
   endtask

   // *******************************************************************
   // Cycle driver
   // *******************************************************************
   // Sample at the falling edge, then drive the next cycle's inputs
   task automatic step(input consume_op_t req, input logic dma, input logic icw, input logic quiet);
      @(negedge clk);
      s_v0  = instr0_valid;
      s_req = fetch_req_bf;
      if (dma_stall || ic_write_stall)
         check_flag("fetch_req_bf", fetch_req_bf, 1'b0);   // Stall holds the request
      if (quiet) begin
         check_flag("fetch_req_bf", fetch_req_bf, 1'b0);
         check_flag("instr0_valid", instr0_valid, 1'b0);
      end
      // Two only when both slots hold a word
      if (req == CONSUME_TWO && instr1_valid) begin
         take_word("instr0", instr0_addr, instr0_word);
         take_word("instr1", instr1_addr, instr1_word);
      end else if (req != CONSUME_NONE && instr0_valid) begin
         take_word("instr0", instr0_addr, instr0_word);
      end
      decode_req     = req;
      dma_stall      = dma;
      ic_write_stall = icw;
      flush          = 1'b0;
      flush_noredir  = 1'b0;
   endtask

   task automatic apply_flush(input int r);
      @(negedge clk);
      flush          = 1'b1;
      flush_path     = rows[r].addr[31:1];
      flush_noredir  = rows[r].noredir;
      decode_req     = CONSUME_NONE;
      dma_stall      = 1'b0;
      ic_write_stall = 1'b0;
      #1;                                                   // Flags settle in the flush cycle
      check_addr("fetch_addr_bf", fetch_addr_bf, rows[r].addr[31:1]);
      check_flag("iccm_access_bf", iccm_access_bf, rows[r].iccm);
      check_flag("region_fault_bf", region_fault_bf, rows[r].fault);
      check_flag("uncacheable_bf", uncacheable_bf, rows[r].unc);
      exp_addr = rows[r].addr;
      got_cnt  = 0;
   endtask

   task automatic run_row(input int r);
      int wait_cnt;
      int prev;
      apply_flush(r);
      if (rows[r].noredir) begin
         for (int c = 0; c < HALT_CYC; c++)
            step(CONSUME_NONE, 1'b0, 1'b0, 1'b1);
      end else begin
         for (int c = 0; c < int'(rows[r].stall_len); c++)
            step(CONSUME_NONE, ~rows[r].stall_wr, rows[r].stall_wr, 1'b0);
         if (rows[r].mode == M_BP) begin
            wait_cnt = 0;
            do begin
               step(CONSUME_NONE, 1'b0, 1'b0, 1'b0);
               wait_cnt++;
               if (wait_cnt > TIMEOUT) fail_run("Timeout waiting for instr0_valid");
            end while (!s_v0);
            wait_cnt = 0;
            do begin
               step(CONSUME_NONE, 1'b0, 1'b0, 1'b0);
               wait_cnt++;
               if (wait_cnt > TIMEOUT) fail_run("Timeout waiting for the request to drop");
            end while (s_req);
            for (int c = 0; c < HOLD_CYC; c++) begin
               step(CONSUME_NONE, 1'b0, 1'b0, 1'b0);
               check_flag("fetch_req_bf", s_req, 1'b0);     // Buffer stays full
            end
         end
         wait_cnt = 0;
         while (got_cnt < int'(rows[r].nwords)) begin
            prev = got_cnt;
            step(req_for(rows[r].mode), 1'b0, 1'b0, 1'b0);
            if (got_cnt != prev) wait_cnt = 0;
            else wait_cnt++;
            if (wait_cnt > TIMEOUT) fail_run("Timeout waiting for fetched instructions");
         end
      end
   endtask

   // *******************************************************************
   // Stimulus table and main sequence
   // *******************************************************************
   initial begin
      void'($urandom(28));
      $readmemh("fetch_rom.hex", rom);
      clk = 1'b0; arst_n = 1'b0;
      flush = 1'b0; flush_path = '0; flush_noredir = 1'b0;
      dma_stall = 1'b0; ic_write_stall = 1'b0;
      mrac = MRAC_VAL; decode_req = CONSUME_NONE;
      exp_addr = '0; got_cnt = 0; s_v0 = 1'b0; s_req = 1'b0;
      //           addr           nored len    wr    mode   words  iccm  fault unc
      rows[0] = '{32'h0000_0000, 1'b0, 8'd0, 1'b0, M_ONE, 8'd12, 1'b0, 1'b0, 1'b0}; // Cold miss
      rows[1] = '{32'h0000_0000, 1'b0, 8'd0, 1'b0, M_TWO, 8'd12, 1'b0, 1'b0, 1'b0}; // Warm pass
      rows[2] = '{32'h0000_0016, 1'b0, 8'd0, 1'b0, M_TWO, 8'd10, 1'b0, 1'b0, 1'b0}; // Line wrap
      rows[3] = '{32'h0000_0040, 1'b0, 8'd0, 1'b0, M_BP,  8'd16, 1'b0, 1'b0, 1'b0};
      rows[4] = '{32'hE000_0020, 1'b0, 8'd0, 1'b0, M_ONE, 8'd8,  1'b1, 1'b0, 1'b0}; // ICCM
      rows[5] = '{32'hE000_0200, 1'b0, 8'd0, 1'b0, M_RND, 8'd8,  1'b0, 1'b1, 1'b0}; // Fault
      rows[6] = '{32'h0000_0080, 1'b1, 8'd0, 1'b0, M_ONE, 8'd0,  1'b0, 1'b0, 1'b0}; // Halt
      rows[7] = '{32'h2000_0030, 1'b0, 8'd6, 1'b0, M_TWO, 8'd10, 1'b0, 1'b0, 1'b1};
      rows[8] = '{32'h1000_00F8, 1'b0, 8'd5, 1'b1, M_RND, 8'd12, 1'b0, 1'b0, 1'b0};
      rows[9] = '{32'hE000_00F0, 1'b0, 8'd0, 1'b0, M_RND, 8'd8,  1'b1, 1'b0, 1'b0}; // Leaves ICCM
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(r);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- fetch_rom.hex
// Instruction words 0 to 63 in order, four per line; word i is {A0+i, i, i, i}
A0000000 A1010101 A2020202 A3030303
A4040404 A5050505 A6060606 A7070707
A8080808 A9090909 AA0A0A0A AB0B0B0B
AC0C0C0C AD0D0D0D AE0E0E0E AF0F0F0F
B0101010 B1111111 B2121212 B3131313
B4141414 B5151515 B6161616 B7171717
B8181818 B9191919 BA1A1A1A BB1B1B1B
BC1C1C1C BD1D1D1D BE1E1E1E BF1F1F1F
C0202020 C1212121 C2222222 C3232323
C4242424 C5252525 C6262626 C7272727
C8282828 C9292929 CA2A2A2A CB2B2B2B
CC2C2C2C CD2D2D2D CE2E2E2E CF2F2F2F
D0303030 D1313131 D2323232 D3333333
D4343434 D5353535 D6363636 D7373737
D8383838 D9393939 DA3A3A3A DB3B3B3B
DC3C3C3C DD3D3D3D DE3E3E3E DF3F3F3F

//--- source/fb_entry.sv
// Fetch buffer slot: one queue position with write and shift by one or two
`timescale 1ns/1ps

module fb_entry
   import fetch_ctl_pkg::*;
   import fetch_buf_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        flush,
   input  logic        wr_en,        // New word from F stage
   input  fetch_addr_t wr_addr,
   input  instr_word_t wr_word,
   input  logic        consume1,     // Shift queue by one
   input  logic        consume2,     // Shift queue by two
   input  logic        next1_valid,
   input  fetch_addr_t next1_addr,
   input  instr_word_t next1_word,
   input  logic        next2_valid,
   input  fetch_addr_t next2_addr,
   input  instr_word_t next2_word,
   output logic        valid,
   output fetch_addr_t addr,
   output instr_word_t word
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)       valid <= 1'b0;
      else if (flush)    valid <= 1'b0;          // Drop everything on redirect
      else if (wr_en)    valid <= 1'b1;          // Write beats the shift
      else if (consume2) valid <= next2_valid;
      else if (consume1) valid <= next1_valid;
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         addr <= wr_addr;
         word <= wr_word;
      end else if (consume2) begin
         addr <= next2_addr;
         word <= next2_word;
      end else if (consume1) begin
         addr <= next1_addr;
         word <= next1_word;
      end
   end

endmodule

//--- source/fetch_aligner.sv
// Aligner: presents the two oldest buffer slots and decides how many decode takes
`timescale 1ns/1ps

module fetch_aligner
   import fetch_buf_pkg::*;
(
   input  consume_op_t decode_req,
   input  logic        slot0_valid,    // Oldest slot
   input  logic [31:1] slot0_addr,
   input  instr_word_t slot0_word,
   input  logic        slot1_valid,    // Second oldest
   input  logic [31:1] slot1_addr,
   input  instr_word_t slot1_word,
   output logic        fb_consume1,
   output logic        fb_consume2,
   output logic        instr0_valid,
   output logic [31:1] instr0_addr,
   output instr_word_t instr0_word,
   output logic        instr1_valid,
   output logic [31:1] instr1_addr,
   output instr_word_t instr1_word
);

   // *******************************************************************
   // Decode side view
   // *******************************************************************
   assign instr0_valid = slot0_valid;
   assign instr0_addr  = slot0_addr;
   assign instr0_word  = slot0_word;
   assign instr1_valid = slot0_valid & slot1_valid;  // Queue is packed, keep it ordered
   assign instr1_addr  = slot1_addr;
   assign instr1_word  = slot1_word;

   // *******************************************************************
   // Consume strobes
   // *******************************************************************
   always_comb begin
      fb_consume1 = 1'b0;
      fb_consume2 = 1'b0;
      case (decode_req)
         CONSUME_ONE: fb_consume1 = slot0_valid;
         CONSUME_TWO: begin
            if (slot0_valid && slot1_valid)
               fb_consume2 = 1'b1;
            else
               fb_consume1 = slot0_valid;    // Only one there, take what exists
         end
         default: ;                          // Nothing requested
      endcase
   end

endmodule

//--- source/fetch_buf_pkg.sv
// Fetch buffer types: instruction word and decode consume request

package fetch_buf_pkg;

   // One 32-bit word as read from the cache
   typedef logic [31:0] instr_word_t;

   // How many buffer slots decode wants this cycle
   typedef enum logic [1:0] {
      CONSUME_NONE = 2'd0,
      CONSUME_ONE  = 2'd1,
      CONSUME_TWO  = 2'd2
   } consume_op_t;

endpackage

//--- source/fetch_ctl_pkg.sv
// Fetch control types: controller state encoding and halfword fetch address

package fetch_ctl_pkg;

   // Controller states, encoded as in the two-bit flop pair
   typedef enum logic [1:0] {
      IDLE  = 2'b00,  // No fetching until a redirecting flush
      FETCH = 2'b01,  // Sequential fetch
      STALL = 2'b10,  // Requests held by buffer full or stall inputs
      WFM   = 2'b11   // Waiting for the miss buffer to fill
   } ifc_state_t;

   // Halfword address, bit 0 is always zero and not carried
   typedef logic [31:1] fetch_addr_t;

endpackage

//--- source/fetch_defs.svh
// Fetch front end sizing: buffer depth, cache geometry, miss timing, ICCM window, ROM
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// *******************************************************************
// Fetch buffer
// *******************************************************************
`define FB_DEPTH        4              // Slots, also width of one-hot write pointer

// *******************************************************************
// Instruction cache model
// *******************************************************************
`define ICACHE_LINES    8              // Direct mapped lines
`define ICACHE_LINE_LO  4              // Lowest index bit, 16 byte lines
`define MISS_CYCLES     4              // Miss buffer busy time before the fill

// *******************************************************************
// Closely coupled memory and backing ROM
// *******************************************************************
`define ICCM_SADR       32'hE000_0000  // ICCM start, byte address
`define ICCM_SIZE       32'h0000_0100  // ICCM size in bytes
`define ROM_WORDS       64             // Indexed by address bits 7:2

`endif

//--- source/icache_model.sv
// Instruction cache model: direct mapped tags over a ROM with a blocking miss buffer
`timescale 1ns/1ps
`include "fetch_defs.svh"

module icache_model
   import fetch_ctl_pkg::*;
   import fetch_buf_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  fetch_addr_t fetch_addr_bf,
   input  logic        fetch_req_bf,
   input  logic        iccm_access_bf,   // ICCM is never cached, always hits
   input  logic        flush,            // Discards the F request
   output logic        ic_hit_f,
   output instr_word_t fetch_word_f,
   output logic        mb_empty          // No fill outstanding
);

   localparam int IDX_W  = $clog2(`ICACHE_LINES);
   localparam int TAG_LO = `ICACHE_LINE_LO + IDX_W;
   localparam int ROM_AW = $clog2(`ROM_WORDS);
   localparam int CNT_W  = $clog2(`MISS_CYCLES + 1);

   instr_word_t              rom [`ROM_WORDS];
   logic [31:TAG_LO]         tag_mem [`ICACHE_LINES];
   logic [`ICACHE_LINES-1:0] tag_valid;
   logic                     req_f, iccm_f;
   fetch_addr_t              addr_f;
   logic [IDX_W-1:0]         idx_f, mb_idx;
   logic [31:TAG_LO]         mb_tag;
   logic                     mb_busy;
   logic [CNT_W-1:0]         mb_cnt;      // Cycles left before the fill
   logic                     start_miss, fill;

   initial $readmemh("fetch_rom.hex", rom);

   assign idx_f        = addr_f[TAG_LO-1:`ICACHE_LINE_LO];
   assign ic_hit_f     = req_f & (iccm_f | (tag_valid[idx_f] & (tag_mem[idx_f] == addr_f[31:TAG_LO])));
   assign fetch_word_f = rom[addr_f[ROM_AW+1:2]];       // Same backing store for all regions
   assign mb_empty     = ~mb_busy;
   assign start_miss   = req_f & ~ic_hit_f & ~mb_busy & ~flush;
   assign fill         = mb_busy & (mb_cnt == '0);

   // Control state
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_f     <= 1'b0;
         iccm_f    <= 1'b0;
         mb_busy   <= 1'b0;
         mb_cnt    <= '0;
         tag_valid <= '0;
      end else begin
         req_f  <= fetch_req_bf;
         iccm_f <= iccm_access_bf;
         if (start_miss) begin
            mb_busy <= 1'b1;
            mb_cnt  <= CNT_W'(`MISS_CYCLES - 1);
         end else if (fill) begin
            mb_busy           <= 1'b0;             // Fill runs to the end, even across flush
            tag_valid[mb_idx] <= 1'b1;
         end else if (mb_busy) begin
            mb_cnt <= mb_cnt - 1'b1;
         end
      end
   end

   // Address, miss buffer payload and tag storage
   always_ff @(posedge clk) begin
      addr_f <= fetch_addr_bf;
      if (start_miss) begin
         mb_idx <= idx_f;
         mb_tag <= addr_f[31:TAG_LO];
      end
      if (fill) tag_mem[mb_idx] <= mb_tag;
   end

endmodule

//--- source/ifc_ctl.sv
// Fetch pipe controller: next address select, FSM, buffer write tracking, region flags
`timescale 1ns/1ps
`include "fetch_defs.svh"

module ifc_ctl
   import fetch_ctl_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 flush,            // Redirect this cycle
   input  fetch_addr_t          flush_path,       // Redirect target
   input  logic                 flush_noredir,    // Halt, do not fetch after flush
   input  logic                 ic_hit_f,         // Cache hit for the F request
   input  logic                 mb_empty,         // Miss buffer idle
   input  logic                 fb_consume1,      // Aligner took one slot
   input  logic                 fb_consume2,      // Aligner took two slots
   input  logic                 dma_stall,
   input  logic                 ic_write_stall,
   input  logic [31:0]          mrac,             // Two bits per region, bit 0 cacheable
   output fetch_addr_t          fetch_addr_bf,
   output fetch_addr_t          fetch_addr_f,
   output logic                 fetch_req_bf,
   output logic                 fetch_req_f,
   output logic [`FB_DEPTH-1:0] fb_wr_sel,        // One-hot slot for the F word
   output logic                 iccm_access_bf,
   output logic                 region_fault_bf,
   output logic                 uncacheable_bf
);

   localparam logic [`FB_DEPTH-1:0] SLOT0     = `FB_DEPTH'(1);
   localparam logic [31:0]          ICCM_BASE = `ICCM_SADR;
   localparam logic [31:0]          ICCM_EADR = `ICCM_SADR + `ICCM_SIZE;

   ifc_state_t           state, next_state;
   logic [31:2]          seq_word;                // Next word of the F address
   fetch_addr_t          fetch_addr_next;
   logic                 line_wrap;
   logic                 sel_last;
   logic                 miss_f, miss_a;
   logic                 mb_empty_mod, goto_idle, leave_idle, idle;
   logic                 wr_f;                    // F word goes into the buffer
   logic                 fb_right, fb_right2, fb_left;
   logic [`FB_DEPTH-1:0] fb_write_f, fb_write_ns;
   logic                 fb_full_ns, stall_req;
   logic [31:0]          byte_addr_bf;

   // *******************************************************************
   // Address select
   // *******************************************************************
   assign seq_word        = fetch_addr_f[31:2] + 30'd1;
   assign line_wrap       = seq_word[`ICACHE_LINE_LO] ^ fetch_addr_f[`ICACHE_LINE_LO];
   assign fetch_addr_next = {seq_word, line_wrap ? 1'b0 : fetch_addr_f[1]}; // Realign on wrap
   assign sel_last        = ~fetch_req_f | ~ic_hit_f;  // Miss or nothing in F, refetch

   always_comb begin
      if (flush)         fetch_addr_bf = flush_path;
      else if (sel_last) fetch_addr_bf = fetch_addr_f;
      else               fetch_addr_bf = fetch_addr_next;
   end

   // *******************************************************************
   // Request and FSM
   // *******************************************************************
   assign idle       = (state == IDLE);
   assign miss_f     = fetch_req_f & ~ic_hit_f & ~flush;
   assign goto_idle  = flush & flush_noredir;           // Halt flush
   assign leave_idle = flush & ~flush_noredir & idle;
   assign stall_req  = fb_full_ns | dma_stall | ic_write_stall;
   // Flush counts as empty since a blocked miss no longer matters
   assign mb_empty_mod = (mb_empty | flush) & ~dma_stall & ~miss_f & ~miss_a;

   // Idle only releases on a redirecting flush, which requests at once
   assign fetch_req_bf = (~idle | leave_idle) & ~stall_req & ~flush_noredir;

   always_comb begin
      next_state = state;
      case (state)
         IDLE:  if (leave_idle) next_state = FETCH;
         FETCH: begin
            if (miss_f)         next_state = WFM;
            else if (stall_req) next_state = STALL;
         end
         STALL: begin
            if (miss_f)          next_state = WFM;
            else if (!stall_req) next_state = FETCH;
         end
         WFM:   if (mb_empty_mod) next_state = FETCH;
         default: next_state = IDLE;
      endcase
      if (goto_idle) next_state = IDLE;                 // Halt wins over everything
   end

   // *******************************************************************
   // Buffer write pointer
   // *******************************************************************
   assign wr_f      = fetch_req_f & ic_hit_f & ~flush;
   assign fb_right  = (fb_consume1 & ~fb_consume2 & ~wr_f) | (fb_consume2 & wr_f); // Net -1
   assign fb_right2 = fb_consume2 & ~wr_f;                                       // Net -2
   assign fb_left   = wr_f & ~fb_consume1 & ~fb_consume2;                        // Net +1

   always_comb begin
      if (flush)          fb_write_ns = SLOT0;
      else if (fb_right2) fb_write_ns = {2'b00, fb_write_f[`FB_DEPTH-1:2]};
      else if (fb_right)  fb_write_ns = {1'b0, fb_write_f[`FB_DEPTH-1:1]};
      else if (fb_left)   fb_write_ns = {fb_write_f[`FB_DEPTH-2:0], 1'b0};
      else                fb_write_ns = fb_write_f;
   end

   // Top slot reached, next pointer already nets out this cycle's consumes
   assign fb_full_ns = fb_write_ns[`FB_DEPTH-1];

   // Slot seen after the aligner shifts the queue this cycle
   always_comb begin
      if (!wr_f)            fb_wr_sel = '0;
      else if (fb_consume2) fb_wr_sel = fb_write_f >> 2;
      else if (fb_consume1) fb_wr_sel = fb_write_f >> 1;
      else                  fb_wr_sel = fb_write_f;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state        <= IDLE;
         fetch_req_f  <= 1'b0;
         miss_a       <= 1'b0;
         fb_write_f   <= SLOT0;
         fetch_addr_f <= '0;
      end else begin
         state       <= next_state;
         fetch_req_f <= fetch_req_bf;
         miss_a      <= miss_f;
         fb_write_f  <= fb_write_ns;
         if (flush | fetch_req_f) fetch_addr_f <= fetch_addr_bf; // Hold while stalled
      end
   end

   // *******************************************************************
   // Region checks
   // *******************************************************************
   assign byte_addr_bf    = {fetch_addr_bf, 1'b0};
   assign iccm_access_bf  = (byte_addr_bf >= ICCM_BASE) & (byte_addr_bf < ICCM_EADR);
   // ICCM region outside the populated window
   assign region_fault_bf = (byte_addr_bf[31:28] == ICCM_BASE[31:28]) & ~iccm_access_bf;
   assign uncacheable_bf  = ~mrac[{byte_addr_bf[31:28], 1'b0}]; // Even bit is cacheable

endmodule

//--- source/ifu_fetch_top.sv
// Fetch front end top: controller, cache model, fetch buffer slots and aligner
`timescale 1ns/1ps
`include "fetch_defs.svh"

module ifu_fetch_top
   import fetch_ctl_pkg::*;
   import fetch_buf_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        flush,
   input  fetch_addr_t flush_path,
   input  logic        flush_noredir,
   input  logic        dma_stall,
   input  logic        ic_write_stall,
   input  logic [31:0] mrac,
   input  consume_op_t decode_req,
   output logic        instr0_valid,
   output fetch_addr_t instr0_addr,
   output instr_word_t instr0_word,
   output logic        instr1_valid,
   output fetch_addr_t instr1_addr,
   output instr_word_t instr1_word,
   output fetch_addr_t fetch_addr_bf,
   output logic        fetch_req_bf,
   output logic        iccm_access_bf,
   output logic        region_fault_bf,
   output logic        uncacheable_bf
);

   fetch_addr_t          fetch_addr_f;
   instr_word_t          fetch_word_f;
   logic                 ic_hit_f, mb_empty;
   logic                 fb_consume1, fb_consume2;
   logic [`FB_DEPTH-1:0] fb_wr_sel;
   // Two extra positions past the tail feed invalid into the last slots
   logic [`FB_DEPTH+1:0] fb_valid;
   fetch_addr_t          fb_addr [`FB_DEPTH+2];
   instr_word_t          fb_word [`FB_DEPTH+2];

   ifc_ctl ifc_ctl_inst (
      .clk, .arst_n, .flush, .flush_path, .flush_noredir,
      .ic_hit_f, .mb_empty, .fb_consume1, .fb_consume2,
      .dma_stall, .ic_write_stall, .mrac,
      .fetch_addr_bf, .fetch_addr_f, .fetch_req_bf,
      .fetch_req_f    (),               // F valid stays inside the controller
      .fb_wr_sel, .iccm_access_bf, .region_fault_bf, .uncacheable_bf
   );

   icache_model icache_model_inst (
      .clk, .arst_n, .fetch_addr_bf, .fetch_req_bf, .iccm_access_bf, .flush,
      .ic_hit_f, .fetch_word_f, .mb_empty
   );

   // *******************************************************************
   // Fetch buffer
   // *******************************************************************
   assign fb_valid[`FB_DEPTH+1:`FB_DEPTH] = 2'b00;
   assign fb_addr[`FB_DEPTH]   = '0;
   assign fb_addr[`FB_DEPTH+1] = '0;
   assign fb_word[`FB_DEPTH]   = '0;
   assign fb_word[`FB_DEPTH+1] = '0;

   for (genvar i = 0; i < `FB_DEPTH; i++) begin : g_fb
      fb_entry fb_entry_inst (
         .clk, .arst_n, .flush,
         .wr_en       (fb_wr_sel[i]),
         .wr_addr     (fetch_addr_f),
         .wr_word     (fetch_word_f),
         .consume1    (fb_consume1),
         .consume2    (fb_consume2),
         .next1_valid (fb_valid[i+1]),
         .next1_addr  (fb_addr[i+1]),
         .next1_word  (fb_word[i+1]),
         .next2_valid (fb_valid[i+2]),
         .next2_addr  (fb_addr[i+2]),
         .next2_word  (fb_word[i+2]),
         .valid       (fb_valid[i]),
         .addr        (fb_addr[i]),
         .word        (fb_word[i])
      );
   end

   fetch_aligner fetch_aligner_inst (
      .decode_req,
      .slot0_valid (fb_valid[0]), .slot0_addr (fb_addr[0]), .slot0_word (fb_word[0]),
      .slot1_valid (fb_valid[1]), .slot1_addr (fb_addr[1]), .slot1_word (fb_word[1]),
      .fb_consume1, .fb_consume2,
      .instr0_valid, .instr0_addr, .instr0_word,
      .instr1_valid, .instr1_addr, .instr1_word
   );

endmodule

//--- vlog.f
+incdir+source
source/fetch_ctl_pkg.sv
source/fetch_buf_pkg.sv
source/ifc_ctl.sv
source/icache_model.sv
source/fb_entry.sv
source/fetch_aligner.sv
source/ifu_fetch_top.sv
bench/ifu_fetch_tb.sv
